// File: logic/memCtrl_defines.svh
`ifndef MEMCTRL_DEFINES_SVH
`define MEMCTRL_DEFINES_SVH

// byte address width seen by the core
`define AddrWidth 32

// low address bits decoded by the byte RAM, 4 KiB
`define RamAddrBits 12

// stores to this address go to the output FIFO
`define IoAddr 32'h0003_0000

// output FIFO entries, power of two
`define IoFifoDepth 4

`endif

// File: logic/memPkg.sv
`include "memCtrl_defines.svh"

package memPkg;

    typedef logic [`AddrWidth-1:0] addrWord;
    typedef logic [31:0] dataWord;
    typedef logic [7:0] memByte;

    // byte count of an access, 1, 2 or 4
    typedef logic [2:0] accessLen;

    typedef enum logic {
        Load,
        Store
    } accessKind;

    typedef enum logic [1:0] {
        Idle,
        ReadInst,
        ReadData,
        WriteData
    } ctrlState;

endpackage

// File: logic/byteRam.sv
`include "memCtrl_defines.svh"

module byteRam
    import memPkg::*;
(
    input  logic    clk,
    input  logic    we,
    input  addrWord addr,
    input  memByte  wrByte,
    output memByte  rdByte
);

    localparam int Bytes = 1 << `RamAddrBits;

    memByte mem [Bytes];
    logic [`RamAddrBits-1:0] index;

    // upper address bits alias onto the same bytes
    assign index = addr[`RamAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wrByte;
        end
        // read data lands one cycle after the address
        rdByte <= mem[index];
    end

endmodule

// File: logic/ioFifo.sv
`include "memCtrl_defines.svh"

module ioFifo
    import memPkg::*;
#(
    parameter int Depth = `IoFifoDepth
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  memByte pushByte,
    output logic   full,
    input  logic   take,
    output logic   valid,
    output memByte headByte
);

    localparam int PtrBits = $clog2(Depth);

    memByte store [Depth];
    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [PtrBits:0]   count;
    logic doPush;
    logic doTake;

    assign full = (count == (PtrBits + 1)'(Depth));
    assign valid = (count != '0);
    assign headByte = store[rdPtr];

    // pushes while full and pops while empty are dropped
    assign doPush = push && !full;
    assign doTake = take && valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            // depth is a power of two so the pointers wrap on their own
            if (doPush) begin
                wrPtr <= wrPtr + PtrBits'(1);
            end
            if (doTake) begin
                rdPtr <= rdPtr + PtrBits'(1);
            end
            case ({doPush, doTake})
                2'b10: count <= count + (PtrBits + 1)'(1);
                2'b01: count <= count - (PtrBits + 1)'(1);
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            store[wrPtr] <= pushByte;
        end
    end

endmodule

// File: logic/memCtrl.sv
`include "memCtrl_defines.svh"

module memCtrl
    import memPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,
    input  logic      ioFull,
    // fetch port
    input  logic      fetchEn,
    input  addrWord   fetchAddr,
    output logic      fetchDone,
    output dataWord   fetchInst,
    // data port
    input  logic      dataEn,
    input  accessKind dataKind,
    input  accessLen  dataLen,
    input  addrWord   dataAddr,
    input  dataWord   dataWrite,
    output logic      dataDone,
    output dataWord   dataRead,
    // byte RAM
    output addrWord   ramAddr,
    output logic      ramWe,
    output memByte    ramWrite,
    input  memByte    ramRead,
    // I/O FIFO
    output logic      ioPush,
    output memByte    ioPushByte
);

    ctrlState   state;
    logic [2:0] step;
    logic       fetchDoneQ;
    logic       dataDoneQ;
    addrWord    addrReg;
    accessLen   lenReg;
    dataWord    word;

    logic       active;
    logic       canAccept;
    logic       acceptData;
    logic       acceptFetch;
    logic       ioTarget;
    logic       lastStep;
    logic [2:0] addrOffset;
    memByte     stepByte;

    assign active = rdy && !ioFull;
    assign canAccept = active && (state == Idle) && !fetchDoneQ && !dataDoneQ;
    // data port wins over fetch
    assign acceptData = canAccept && dataEn;
    assign acceptFetch = canAccept && !dataEn && fetchEn;

    assign ioTarget = (addrReg == `IoAddr);

    // reads run one step longer than writes to catch the last RAM byte
    always_comb begin
        if (state == WriteData) begin
            lastStep = (step == lenReg - 3'd1);
        end else begin
            lastStep = (step == lenReg);
        end
    end

    // while frozen, keep re-reading the byte the assembler still owes
    assign addrOffset = active ? step : step - 3'd1;
    assign ramAddr = addrReg + addrWord'(addrOffset);

    always_comb begin
        case (step[1:0])
            2'd0: stepByte = word[7:0];
            2'd1: stepByte = word[15:8];
            2'd2: stepByte = word[23:16];
            default: stepByte = word[31:24];
        endcase
    end

    assign ramWrite = stepByte;
    assign ioPushByte = stepByte;
    assign ramWe = active && (state == WriteData) && !ioTarget;
    assign ioPush = active && (state == WriteData) && ioTarget;

    assign fetchDone = fetchDoneQ && active;
    assign dataDone = dataDoneQ && active;
    assign fetchInst = word;
    assign dataRead = word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= Idle;
            step <= 3'd0;
            fetchDoneQ <= 1'b0;
            dataDoneQ <= 1'b0;
        end else if (active) begin
            fetchDoneQ <= 1'b0;
            dataDoneQ <= 1'b0;
            case (state)
                Idle: begin
                    step <= 3'd0;
                    if (acceptData) begin
                        state <= (dataKind == Store) ? WriteData : ReadData;
                    end else if (acceptFetch) begin
                        state <= ReadInst;
                    end
                end
                default: begin
                    step <= step + 3'd1;
                    if (lastStep) begin
                        state <= Idle;
                        if (state == ReadInst) begin
                            fetchDoneQ <= 1'b1;
                        end else begin
                            dataDoneQ <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // request latch and byte assembly
    always_ff @(posedge clk) begin
        if (acceptData) begin
            addrReg <= dataAddr;
            lenReg <= dataLen;
            word <= (dataKind == Store) ? dataWrite : '0;
        end else if (acceptFetch) begin
            addrReg <= fetchAddr;
            lenReg <= 3'd4;
            word <= '0;
        end else if (active && (state == ReadInst || state == ReadData)) begin
            // byte issued last step comes back now
            case (step)
                3'd1: word[7:0] <= ramRead;
                3'd2: word[15:8] <= ramRead;
                3'd3: word[23:16] <= ramRead;
                3'd4: word[31:24] <= ramRead;
                default: ;
            endcase
        end
    end

endmodule

// File: logic/memSubsystem.sv
module memSubsystem
    import memPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,
    // fetch port
    input  logic      fetchEn,
    input  addrWord   fetchAddr,
    output logic      fetchDone,
    output dataWord   fetchInst,
    // data port
    input  logic      dataEn,
    input  accessKind dataKind,
    input  accessLen  dataLen,
    input  addrWord   dataAddr,
    input  dataWord   dataWrite,
    output logic      dataDone,
    output dataWord   dataRead,
    // I/O output
    output logic      ioValid,
    output memByte    ioByte,
    input  logic      ioTake
);

    addrWord ramAddr;
    logic    ramWe;
    memByte  ramWrite;
    memByte  ramRead;
    logic    ioPush;
    memByte  ioPushByte;
    logic    ioFull;

    memCtrl ctrl0 (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .ioFull     (ioFull),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .dataEn     (dataEn),
        .dataKind   (dataKind),
        .dataLen    (dataLen),
        .dataAddr   (dataAddr),
        .dataWrite  (dataWrite),
        .dataDone   (dataDone),
        .dataRead   (dataRead),
        .ramAddr    (ramAddr),
        .ramWe      (ramWe),
        .ramWrite   (ramWrite),
        .ramRead    (ramRead),
        .ioPush     (ioPush),
        .ioPushByte (ioPushByte)
    );

    byteRam ram0 (
        .clk    (clk),
        .we     (ramWe),
        .addr   (ramAddr),
        .wrByte (ramWrite),
        .rdByte (ramRead)
    );

    // drained from outside, keeps popping while the controller is frozen
    ioFifo fifo0 (
        .clk      (clk),
        .rst      (rst),
        .push     (ioPush),
        .pushByte (ioPushByte),
        .full     (ioFull),
        .take     (ioTake),
        .valid    (ioValid),
        .headByte (ioByte)
    );

endmodule

// File: bench/memTasks.svh
`ifndef MEMTASKS_SVH
`define MEMTASKS_SVH

localparam int WaitLimit = 100;

// taps 32, 22, 2, 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsrState = lfsrNext(lfsrState);
        r = {r[30:0], lfsrState[0]};
    end
    return r;
endfunction

function automatic logic [`RamAddrBits-1:0] ramIndex(input addrWord addr, input int i);
    addrWord a;
    a = addr + addrWord'(i);
    return a[`RamAddrBits-1:0];
endfunction

// little-endian, zero-extended
function automatic dataWord refWord(input addrWord addr, input int len);
    dataWord w;
    w = '0;
    for (int i = 0; i < len; i++) begin
        w[8*i +: 8] = refMem[ramIndex(addr, i)];
    end
    return w;
endfunction

task automatic finishTest(input string name);
    if (errors == 0) begin
        testsPassed++;
        $display("%s: ok", name);
    end else begin
        testsFailed++;
        $display("%s: %0d errors", name, errors);
    end
    errors = 0;
endtask

task automatic checkWord(input string sig, input dataWord got, input dataWord exp);
    assert (got === exp) else begin
        $display("Mismatch %s expected %h got %h", sig, exp, got);
        errors++;
    end
endtask

task automatic checkCycles(input string what, input int got, input int exp);
    assert (got == exp) else begin
        $display("%s finished after %0d cycles instead of %0d", what, got, exp);
        errors++;
    end
endtask

task automatic expectSeen(input bit seen, input string what, input int cycles);
    ctrlState st;
    st = dut0.ctrl0.state;
    assert (seen) else begin
        $display("%s did not finish within %0d cycles, controller in state %s",
            what, cycles, st.name());
        errors++;
    end
endtask

task automatic startData(input accessKind kind, input addrWord addr, input int len,
        input dataWord wdata);
    @(negedge clk);
    dataEn = 1'b1;
    dataKind = kind;
    dataLen = accessLen'(len);
    dataAddr = addr;
    dataWrite = wdata;
endtask

// outputs sampled mid-cycle
task automatic waitDone(input bit fetchPort, output int cycles, output dataWord result);
    bit seen;
    seen = 1'b0;
    cycles = 0;
    result = '0;
    while (!seen && cycles < WaitLimit) begin
        @(negedge clk);
        cycles++;
        assert (fetchPort ? !dataDone : !fetchDone) else begin
            $display("done pulse on the port that was not being waited for");
            errors++;
        end
        if (fetchPort ? fetchDone : dataDone) begin
            seen = 1'b1;
            result = fetchPort ? fetchInst : dataRead;
        end
    end
    expectSeen(seen, fetchPort ? "fetch" : "data access", cycles);
endtask

task automatic storeBytes(input addrWord addr, input int len, input dataWord wdata);
    int cycles;
    dataWord unused;
    startData(Store, addr, len, wdata);
    waitDone(1'b0, cycles, unused);
    dataEn = 1'b0;
    if (addr == `IoAddr) begin
        checkCycles("I/O store", cycles, 2);
    end else begin
        for (int i = 0; i < len; i++) begin
            refMem[ramIndex(addr, i)] = wdata[8*i +: 8];
        end
        checkCycles("store", cycles, len + 1);
    end
endtask

task automatic loadAndCheck(input addrWord addr, input int len);
    int cycles;
    dataWord got;
    startData(Load, addr, len, '0);
    waitDone(1'b0, cycles, got);
    dataEn = 1'b0;
    checkWord("dataRead", got, refWord(addr, len));
    checkCycles("load", cycles, len + 2);
endtask

task automatic fetchAndCheck(input addrWord addr);
    int cycles;
    dataWord got;
    @(negedge clk);
    fetchEn = 1'b1;
    fetchAddr = addr;
    waitDone(1'b1, cycles, got);
    fetchEn = 1'b0;
    checkWord("fetchInst", got, refWord(addr, 4));
    checkCycles("fetch", cycles, 6);
endtask

task automatic storeLoadTest();
    storeBytes(32'h40, 4, 32'h1234_5678);
    storeBytes(32'h44, 4, 32'h9abc_def0);
    storeBytes(32'h48, 4, 32'h0f1e_2d3c);
    storeBytes(32'h4c, 4, 32'hcafe_f00d);
    storeBytes(32'h46, 2, 32'h0000_beef);
    storeBytes(32'h49, 1, 32'h0000_00a5);
    storeBytes(32'h4b, 2, 32'h0000_7e81);
    loadAndCheck(32'h40, 4);
    loadAndCheck(32'h41, 1);
    loadAndCheck(32'h42, 2);
    loadAndCheck(32'h45, 4);
    loadAndCheck(32'h46, 2);
    loadAndCheck(32'h49, 1);
    loadAndCheck(32'h4a, 4);
    loadAndCheck(32'h4c, 4);
    finishTest("stores then loads");
endtask

task automatic fetchTest();
    storeBytes(32'h80, 1, 32'h93);
    storeBytes(32'h81, 1, 32'h05);
    storeBytes(32'h82, 1, 32'h10);
    storeBytes(32'h83, 1, 32'h00);
    fetchAndCheck(32'h80);
    finishTest("fetch");
endtask

task automatic priorityTest();
    int cycles;
    dataWord got;
    startData(Load, 32'h44, 4, '0);
    fetchEn = 1'b1;
    fetchAddr = 32'h80;
    // an early fetch done is caught inside the wait
    waitDone(1'b0, cycles, got);
    dataEn = 1'b0;
    checkWord("dataRead", got, refWord(32'h44, 4));
    checkCycles("load", cycles, 6);
    waitDone(1'b1, cycles, got);
    fetchEn = 1'b0;
    checkWord("fetchInst", got, refWord(32'h80, 4));
    checkCycles("fetch after load", cycles, 7);
    finishTest("priority");
endtask

task automatic stallTest();
    int cycles;
    dataWord got;
    startData(Load, 32'h4a, 4, '0);
    repeat (2) @(negedge clk);
    rdy = 1'b0;
    repeat (10) begin
        @(negedge clk);
        assert (!dataDone && !fetchDone) else begin
            $display("done pulse while rdy was low");
            errors++;
        end
    end
    rdy = 1'b1;
    waitDone(1'b0, cycles, got);
    dataEn = 1'b0;
    checkWord("dataRead", got, refWord(32'h4a, 4));
    checkCycles("stalled load", cycles + 12, 4 + 2 + 10);
    finishTest("ready stall");
endtask

task automatic ioTest();
    memByte pushed [4];
    int popped;
    int cycles;
    bit dataSeen;
    bit fetchSeen;
    dataWord inst;
    pushed = '{8'h11, 8'h22, 8'h33, 8'h44};
    // RAM index 0 aliases the I/O address
    storeBytes(32'h0, 4, 32'h0bad_f00d);
    for (int i = 0; i < 3; i++) begin
        storeBytes(`IoAddr, 1, dataWord'(pushed[i]));
    end
    startData(Store, `IoAddr, 1, dataWord'(pushed[3]));
    fetchEn = 1'b1;
    fetchAddr = 32'h0;
    repeat (20) begin
        @(negedge clk);
        assert (!dataDone && !fetchDone) else begin
            $display("request finished while the I/O FIFO was full");
            errors++;
        end
    end
    popped = 0;
    cycles = 0;
    dataSeen = 1'b0;
    fetchSeen = 1'b0;
    inst = '0;
    while ((popped < 4 || !fetchSeen) && cycles < WaitLimit) begin
        if (dataDone) begin
            dataSeen = 1'b1;
            dataEn = 1'b0;
        end
        if (fetchDone) begin
            fetchSeen = 1'b1;
            fetchEn = 1'b0;
            inst = fetchInst;
        end
        if (popped < 4 && ioValid) begin
            checkWord("ioByte", dataWord'(ioByte), dataWord'(pushed[popped]));
            popped++;
            ioTake = 1'b1;
        end else begin
            ioTake = 1'b0;
        end
        @(negedge clk);
        cycles++;
    end
    ioTake = 1'b0;
    dataEn = 1'b0;
    fetchEn = 1'b0;
    expectSeen(dataSeen && fetchSeen && popped == 4, "I/O drain", cycles);
    checkWord("fetchInst", inst, refWord(32'h0, 4));
    checkWord("ioValid", dataWord'(ioValid), 32'h0);
    finishTest("I/O path");
endtask

task automatic randomTest();
    logic [31:0] r;
    bit isStore;
    int len;
    int offset;
    addrWord addr;
    // window 0x100..0x13f, filled first
    for (int a = 'h100; a < 'h140; a += 4) begin
        storeBytes(addrWord'(a), 4, dataWord'(a) * 32'h9e37_79b9);
    end
    for (int k = 0; k < 40; k++) begin
        r = randBits(1);
        isStore = r[0];
        r = randBits(2);
        len = (r[1:0] == 2'd0) ? 1 : (r[1:0] == 2'd1) ? 2 : 4;
        r = randBits(6);
        offset = int'(r[5:0]);
        if (offset + len > 64) begin
            offset = 64 - len;
        end
        addr = 32'h100 + addrWord'(offset);
        if (isStore) begin
            storeBytes(addr, len, randBits(32));
        end else begin
            loadAndCheck(addr, len);
        end
    end
    finishTest("random traffic");
endtask

`endif

// File: bench/memTb.sv
`include "memCtrl_defines.svh"

module memTb
    import memPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic      clk = 1'b0;
    logic      rst;
    logic      rdy;
    logic      fetchEn;
    addrWord   fetchAddr;
    logic      fetchDone;
    dataWord   fetchInst;
    logic      dataEn;
    accessKind dataKind;
    accessLen  dataLen;
    addrWord   dataAddr;
    dataWord   dataWrite;
    logic      dataDone;
    dataWord   dataRead;
    logic      ioValid;
    memByte    ioByte;
    logic      ioTake;

    // mirror of every RAM store
    memByte      refMem [1 << `RamAddrBits];
    logic [31:0] lfsrState;
    // errors of the test in progress
    int          errors;
    int          testsPassed;
    int          testsFailed;

    memSubsystem dut0 (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fetchDone (fetchDone),
        .fetchInst (fetchInst),
        .dataEn    (dataEn),
        .dataKind  (dataKind),
        .dataLen   (dataLen),
        .dataAddr  (dataAddr),
        .dataWrite (dataWrite),
        .dataDone  (dataDone),
        .dataRead  (dataRead),
        .ioValid   (ioValid),
        .ioByte    (ioByte),
        .ioTake    (ioTake)
    );

    always #20 clk = ~clk;

    `include "memTasks.svh"

    initial begin
        rst = 1'b1;
        rdy = 1'b1;
        fetchEn = 1'b0;
        fetchAddr = '0;
        dataEn = 1'b0;
        dataKind = Load;
        dataLen = 3'd4;
        dataAddr = '0;
        dataWrite = '0;
        ioTake = 1'b0;
        lfsrState = 32'hd7c24642;
        errors = 0;
        testsPassed = 0;
        testsFailed = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        storeLoadTest();
        fetchTest();
        priorityTest();
        stallTest();
        ioTest();
        randomTest();

        $display("%0d tests passed, %0d tests failed", testsPassed, testsFailed);
        if (testsFailed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+logic
+incdir+bench
logic/memPkg.sv
logic/byteRam.sv
logic/ioFifo.sv
logic/memCtrl.sv
logic/memSubsystem.sv
bench/memTb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module memTb -o memTb

run: compile
	./obj_dir/memTb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
